// ==== verilog/arrayHeapPkg.sv ====
/* Shared sizes, command word layout, opcode and error encodings for the array heap.
   Every RTL module and the testbench import this package. */

package arrayHeapPkg;

  // --------------------
  // Sizes
  localparam int ArrayCount  = 4;                    // Arrays in the heap
  localparam int ArrayBits   = 2;                    // Width of an array number
  localparam int ArrayLength = 4;                    // Elements per array
  localparam int IndexBits   = 2;                    // Width of an element index
  localparam int SizeBits    = IndexBits + 1;        // Size can reach ArrayLength
  localparam int DataBits    = 16;                   // Element width
  localparam int WordBits    = 32;                   // APB data width
  localparam int AddrBits    = 3;                    // APB address width

  // --------------------
  // Register map
  localparam logic [AddrBits-1:0] CommandAddr = 3'd0; // Write only
  localparam logic [AddrBits-1:0] ResultAddr  = 3'd4; // Read only

  // Command word fields
  localparam int DataLsb   = 0;
  localparam int DataMsb   = 15;
  localparam int IndexLsb  = 16;
  localparam int IndexMsb  = 17;
  localparam int ArrayLsb  = 20;
  localparam int ArrayMsb  = 21;
  localparam int OpcodeLsb = 24;
  localparam int OpcodeMsb = 27;

  // --------------------
  // Encodings
  typedef enum logic [3:0] {
    opClear    = 4'd0,                               // Free every array
    opAlloc    = 4'd1,
    opFree     = 4'd2,
    opWrite    = 4'd3,
    opRead     = 4'd4,
    opSize     = 4'd5,
    opPush     = 4'd6,
    opPop      = 4'd7,
    opAdd      = 4'd8,                               // Read-modify-write group
    opSubtract = 4'd9,
    opAnd      = 4'd10,
    opOr       = 4'd11,
    opXor      = 4'd12                               // Codes above are illegal
  } opcodeT;

  typedef enum logic [3:0] {
    noError      = 4'd0,
    notAllocated = 4'd1,                             // Never handed out
    arrayFreed   = 4'd2,                             // Freed or freed twice
    outOfBounds  = 4'd3,
    arrayFull    = 4'd4,
    arrayEmpty   = 4'd5,
    outOfMemory  = 4'd6,
    badOpcode    = 4'd7
  } errorCodeT;

  // Response word decoded by its top bit
  typedef struct packed {
    logic                           isError;         // Zero in this view
    logic [WordBits-DataBits-2:0]   pad;
    logic [DataBits-1:0]            data;
  } resultViewT;

  typedef struct packed {
    logic                           isError;         // One in this view
    logic [WordBits-6:0]            pad;
    errorCodeT                      code;
  } errorViewT;

  typedef union packed {
    resultViewT result;
    errorViewT  error;
  } responseWordT;

endpackage

// ==== verilog/elementStore.sv ====
/* Last stage of the heap pipeline. Holds the element memory, performs the
   element write, read or read-modify-write, and forms the response word that
   goes back to the command port one cycle after the access. */

`timescale 1ns/100ps

module elementStore (
  input  logic                                clock,
  input  logic                                reset,
  // From the check stage
  input  logic                                accessValid,
  input  arrayHeapPkg::opcodeT                accessOpcode,
  input  logic [arrayHeapPkg::ArrayBits-1:0]  accessArray,
  input  logic [arrayHeapPkg::IndexBits-1:0]  accessSlot,
  input  logic [arrayHeapPkg::DataBits-1:0]   accessData,
  input  arrayHeapPkg::errorCodeT             accessFault,
  // To the command port
  output logic                                resultValid,
  output arrayHeapPkg::responseWordT          resultWord
);
  import arrayHeapPkg::*;

  logic [DataBits-1:0] memory [ArrayCount][ArrayLength]; // Fixed block per array

  logic [DataBits-1:0] element;                      // Current element value
  logic [DataBits-1:0] newValue;                     // Arithmetic unit output
  logic [DataBits-1:0] resultData;                   // Data for the result view
  logic                writesMemory;                 // Opcode stores resultData
  responseWordT        nextWord;

  assign element = memory[accessArray][accessSlot];

  // --------------------
  // Arithmetic unit
  always_comb begin
    case (accessOpcode)
      opAdd:      newValue = element + accessData;
      opSubtract: newValue = element - accessData;
      opAnd:      newValue = element & accessData;
      opOr:       newValue = element | accessData;
      opXor:      newValue = element ^ accessData;
      default:    newValue = element;
    endcase
  end

  // Result data and write enable per opcode
  always_comb begin
    writesMemory = 1'b0;
    case (accessOpcode)
      opWrite, opPush: begin
        resultData   = accessData;                   // Echo the stored value
        writesMemory = 1'b1;
      end
      opRead, opPop: resultData = element;
      opAdd, opSubtract, opAnd, opOr, opXor: begin
        resultData   = newValue;                     // New value, not the old one
        writesMemory = 1'b1;
      end
      opAlloc, opSize: resultData = accessData;      // Number or size from the table
      default:         resultData = '0;              // Clear and Free
    endcase
  end

  // --------------------
  // Response formation
  always_comb begin
    nextWord = '0;                                   // Unused bits stay zero
    if (accessFault != noError) begin
      nextWord.error.isError = 1'b1;
      nextWord.error.code    = accessFault;
    end else begin
      nextWord.result.data = resultData;
    end
  end

  always_ff @(posedge clock) begin
    if (accessValid && accessFault == noError && writesMemory) begin
      memory[accessArray][accessSlot] <= resultData;
    end
    if (accessValid) begin
      resultWord <= nextWord;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      resultValid <= 1'b0;
    end else begin
      resultValid <= accessValid;                    // One cycle latency
    end
  end

endmodule

// ==== verilog/arrayTable.sv ====
/* Check stage of the heap pipeline. Holds the allocation state and the array
   sizes, classifies each issued command, commits its state change when it has
   no fault, and passes the element slot and any fault to the element store. */

`timescale 1ns/100ps

module arrayTable (
  input  logic                                clock,
  input  logic                                reset,
  // From the command port
  input  logic                                issueValid,
  input  arrayHeapPkg::opcodeT                issueOpcode,
  input  logic [arrayHeapPkg::ArrayBits-1:0]  issueArray,
  input  logic [arrayHeapPkg::IndexBits-1:0]  issueIndex,
  input  logic [arrayHeapPkg::DataBits-1:0]   issueData,
  // To the element store
  output logic                                accessValid,
  output arrayHeapPkg::opcodeT                accessOpcode,
  output logic [arrayHeapPkg::ArrayBits-1:0]  accessArray,
  output logic [arrayHeapPkg::IndexBits-1:0]  accessSlot,
  output logic [arrayHeapPkg::DataBits-1:0]   accessData,
  output arrayHeapPkg::errorCodeT             accessFault
);
  import arrayHeapPkg::*;

  // --------------------
  // Allocation state
  logic [ArrayBits:0]    handedOut;                  // Arrays ever handed out
  logic [ArrayCount-1:0] allocated;                  // Live flag per array
  logic [ArrayBits-1:0]  freeStack [ArrayCount];     // Freed array numbers
  logic [ArrayBits:0]    freeTop;                    // Entries on the free stack
  logic [SizeBits-1:0]   sizes [ArrayCount];         // Current size per array

  logic [SizeBits-1:0]   curSize;                    // Size of the addressed array
  logic                  reuseFree;                  // Alloc pops the free stack
  logic [ArrayBits-1:0]  allocNumber;                // Number Alloc hands out
  logic                  inBounds;                   // Index below the size
  errorCodeT             ownerFault;                 // Array number checks only
  errorCodeT             fault;
  logic                  commit;                     // Apply the state change
  logic [IndexBits-1:0]  slot;
  logic [DataBits-1:0]   data;

  assign curSize     = sizes[issueArray];
  assign reuseFree   = (freeTop != '0);
  assign allocNumber = reuseFree ? freeStack[freeTop[ArrayBits-1:0] - 1'b1]
                                 : handedOut[ArrayBits-1:0];
  assign inBounds    = ({1'b0, issueIndex} < curSize);
  assign ownerFault  = ({1'b0, issueArray} >= handedOut) ? notAllocated :
                       !allocated[issueArray]          ? arrayFreed   : noError;
  assign commit      = issueValid && (fault == noError);

  // --------------------
  // Fault classification, highest priority first
  always_comb begin
    fault = noError;
    case (issueOpcode)
      opClear:                 fault = noError;
      opAlloc:                 if (!reuseFree && handedOut == ArrayCount) fault = outOfMemory;
      opFree, opWrite, opSize: fault = ownerFault;   // Second Free lands on arrayFreed
      opRead, opAdd, opSubtract, opAnd, opOr, opXor: begin
        fault = ownerFault;
        if (ownerFault == noError && !inBounds) fault = outOfBounds;
      end
      opPush: begin
        fault = ownerFault;
        if (ownerFault == noError && curSize == ArrayLength) fault = arrayFull;
      end
      opPop: begin
        fault = ownerFault;
        if (ownerFault == noError && curSize == '0) fault = arrayEmpty;
      end
      default:                 fault = badOpcode;
    endcase
  end

  // Element position and forwarded data
  always_comb begin
    case (issueOpcode)
      opPush:  slot = curSize[IndexBits-1:0];        // Next free position
      opPop:   slot = IndexBits'(curSize - 1'b1);    // Top element
      default: slot = issueIndex;
    endcase
    case (issueOpcode)
      opAlloc: data = DataBits'(allocNumber);
      opSize:  data = DataBits'(curSize);
      default: data = issueData;
    endcase
  end

  // --------------------
  // Control state
  always_ff @(posedge clock) begin
    if (reset) begin
      accessValid <= 1'b0;
      handedOut   <= '0;
      freeTop     <= '0;
      allocated   <= '0;
    end else begin
      accessValid <= issueValid;                     // One cycle latency
      if (commit) begin
        case (issueOpcode)
          opClear: begin
            handedOut <= '0;
            freeTop   <= '0;
            allocated <= '0;
          end
          opAlloc: begin
            if (reuseFree) freeTop <= freeTop - 1'b1; // Last freed first
            else handedOut <= handedOut + 1'b1;
            allocated[allocNumber] <= 1'b1;
          end
          opFree: begin
            freeTop               <= freeTop + 1'b1;
            allocated[issueArray] <= 1'b0;
          end
          default: ;
        endcase
      end
    end
  end

  // Sizes, free stack entries and stage payload
  always_ff @(posedge clock) begin
    if (issueValid) begin
      accessOpcode <= issueOpcode;
      accessArray  <= issueArray;
      accessSlot   <= slot;
      accessData   <= data;
      accessFault  <= fault;
    end
    if (commit) begin
      case (issueOpcode)
        opAlloc: sizes[allocNumber] <= '0;           // New array starts empty
        opFree:  freeStack[freeTop[ArrayBits-1:0]] <= issueArray;
        opWrite: if (!inBounds) sizes[issueArray] <= SizeBits'(issueIndex) + 1'b1;
        opPush:  sizes[issueArray] <= curSize + 1'b1;
        opPop:   sizes[issueArray] <= curSize - 1'b1;
        default: ;
      endcase
    end
  end

endmodule

// ==== verilog/apbCommandPort.sv ====
/* APB slave for the array heap. A write to the command register issues one
   command and waits until its response returns; a read of the result register
   returns the last response word. */

`timescale 1ns/100ps

module apbCommandPort (
  input  logic                                clock,
  input  logic                                reset,
  // APB
  input  logic                                psel,
  input  logic                                penable,
  input  logic                                pwrite,
  input  logic [arrayHeapPkg::AddrBits-1:0]   paddr,
  input  logic [arrayHeapPkg::WordBits-1:0]   pwdata,
  output logic [arrayHeapPkg::WordBits-1:0]   prdata,
  output logic                                pready,
  output logic                                pslverr,
  // Issue to the check stage
  output logic                                issueValid,
  output arrayHeapPkg::opcodeT                issueOpcode,
  output logic [arrayHeapPkg::ArrayBits-1:0]  issueArray,
  output logic [arrayHeapPkg::IndexBits-1:0]  issueIndex,
  output logic [arrayHeapPkg::DataBits-1:0]   issueData,
  // Response from the element store
  input  logic                                resultValid,
  input  arrayHeapPkg::responseWordT          resultWord
);
  import arrayHeapPkg::*;

  logic         accessPhase;                         // psel and penable both high
  logic         commandWrite;                        // Write to the command register
  logic         resultRead;                          // Read of the result register
  logic         busy;                                // Command in flight
  logic         commandDone;                         // Response just captured
  responseWordT responseReg;                         // Last response word

  // --------------------
  // Address decode
  assign accessPhase  = psel & penable;
  assign commandWrite = pwrite & (paddr == CommandAddr);
  assign resultRead   = !pwrite & (paddr == ResultAddr);

  // Issue once in the first access cycle of a command write
  assign issueValid = accessPhase & commandWrite & !busy & !commandDone;

  // Command word fields
  assign issueOpcode = opcodeT'(pwdata[OpcodeMsb:OpcodeLsb]); // Codes 13 to 15 stay illegal
  assign issueArray  = pwdata[ArrayMsb:ArrayLsb];
  assign issueIndex  = pwdata[IndexMsb:IndexLsb];
  assign issueData   = pwdata[DataMsb:DataLsb];

  // --------------------
  // Command tracking and response register
  always_ff @(posedge clock) begin
    if (reset) begin
      busy        <= 1'b0;
      commandDone <= 1'b0;
      responseReg <= '0;
    end else begin
      commandDone <= resultValid;                    // pready one cycle after the result
      if (issueValid) begin
        busy <= 1'b1;
      end else if (resultValid) begin
        busy <= 1'b0;
      end
      if (resultValid) begin
        responseReg <= resultWord;                   // Held until the next command
      end
    end
  end

  // --------------------
  // APB response
  // Command writes wait for the pipeline, all else completes at once
  assign pready  = commandDone | (accessPhase & !commandWrite);
  assign pslverr = accessPhase & !commandWrite & !resultRead; // Unmapped or wrong direction
  assign prdata  = (accessPhase & resultRead) ? responseReg : '0;

endmodule

// ==== verilog/arrayHeapTop.sv ====
/* Array heap with an APB slave port. Connects the command port to the
   check stage and the element store, which form a three stage pipeline. */

`timescale 1ns/100ps

module arrayHeapTop (
  input  logic                               clock,
  input  logic                               reset,
  input  logic                               psel,
  input  logic                               penable,
  input  logic                               pwrite,
  input  logic [arrayHeapPkg::AddrBits-1:0]  paddr,
  input  logic [arrayHeapPkg::WordBits-1:0]  pwdata,
  output logic [arrayHeapPkg::WordBits-1:0]  prdata,
  output logic                               pready,
  output logic                               pslverr
);
  import arrayHeapPkg::*;

  // --------------------
  // Issue stage to check stage
  logic                 issueValid;
  opcodeT               issueOpcode;
  logic [ArrayBits-1:0] issueArray;
  logic [IndexBits-1:0] issueIndex;
  logic [DataBits-1:0]  issueData;

  // Check stage to element store
  logic                 accessValid;
  opcodeT               accessOpcode;
  logic [ArrayBits-1:0] accessArray;
  logic [IndexBits-1:0] accessSlot;
  logic [DataBits-1:0]  accessData;
  errorCodeT            accessFault;

  // Element store back to the port
  logic                 resultValid;
  responseWordT         resultWord;

  apbCommandPort port (
    .clock, .reset,
    .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
    .issueValid, .issueOpcode, .issueArray, .issueIndex, .issueData,
    .resultValid, .resultWord
  );

  arrayTable table0 (
    .clock, .reset,
    .issueValid, .issueOpcode, .issueArray, .issueIndex, .issueData,
    .accessValid, .accessOpcode, .accessArray, .accessSlot, .accessData, .accessFault
  );

  elementStore store (
    .clock, .reset,
    .accessValid, .accessOpcode, .accessArray, .accessSlot, .accessData, .accessFault,
    .resultValid, .resultWord
  );

endmodule

// ==== testbench/arrayHeapAssertions.sv ====
/* APB protocol and issue checks, bound into every apbCommandPort instance. */

`timescale 1ns/100ps

module arrayHeapAssertions (
  input logic                               clock,
  input logic                               reset,
  input logic                               psel,
  input logic                               penable,
  input logic                               pwrite,
  input logic [arrayHeapPkg::AddrBits-1:0]  paddr,
  input logic [arrayHeapPkg::WordBits-1:0]  pwdata,
  input logic                               pready,
  input logic                               issueValid
);
  import arrayHeapPkg::*;

  // Cycle 0 is the first access cycle, pready lands in cycle 3
  assert property (@(posedge clock) disable iff (reset)
    psel && penable && !$past(penable) && pwrite && paddr == CommandAddr
    |-> !pready [*3] ##1 pready)
    else $error("Command write did not complete after exactly three wait states");

  assert property (@(posedge clock) disable iff (reset) issueValid |=> !issueValid)
    else $error("issueValid stayed high for more than one cycle");  // Single issue per command

  // Host holds the transfer during wait states
  assert property (@(posedge clock) disable iff (reset)
    psel && penable && !pready |=> $stable(paddr) && $stable(pwdata) && $stable(pwrite))
    else $error("APB address, data or direction changed during a wait state");

endmodule

bind apbCommandPort arrayHeapAssertions checks (.*);

// ==== testbench/arrayHeapTb.sv ====
/* Directed testbench for the array heap. Every command goes out over APB, its
   response is read back from the result register and compared with a small
   reference model of the heap. */

`timescale 1ns/100ps

module arrayHeapTb;
  import arrayHeapPkg::*;

  localparam int TimeoutCycles = 20;                 // Longest wait for pready

  logic                clock;
  logic                reset;
  logic                psel;
  logic                penable;
  logic                pwrite;
  logic                pready;
  logic                pslverr;
  logic [AddrBits-1:0] paddr;
  logic [WordBits-1:0] pwdata;
  logic [WordBits-1:0] prdata;

  int                  errorCount = 0;
  int                  timeoutCount = 0;
  logic [31:0]         lcgState = 32'h586;           // Fixed seed
  logic [WordBits-1:0] lastResponse = '0;            // Last word the model predicted

  // Reference model state
  int                  mHandedOut = 0;
  int                  mFreeTop = 0;
  int                  mFreeStack [ArrayCount];
  int                  mSize [ArrayCount];
  logic [ArrayCount-1:0] mAllocated = '0;
  logic [DataBits-1:0] mMem [ArrayCount][ArrayLength];

  arrayHeapTop dut (
    .clock, .reset, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;                       // 4 ns period
  end

  function automatic logic [DataBits-1:0] randomData();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState[31:16];                          // Upper bits are the better ones
  endfunction

  task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
    assert (actual === expected) else begin
      errorCount++;
      $display("FAIL %0t: %s, got %h, expected %h", $time, what, actual, expected);
    end
  endtask

  task automatic stepToDrive();
    @(posedge clock);
    #1;                                              // Drive just after the edge
  endtask

  // --------------------
  // APB transfer with pready sampled mid cycle
  task automatic transfer(input logic write, input logic [AddrBits-1:0] addr,
                          input logic [WordBits-1:0] data, output logic [WordBits-1:0] rdata,
                          output logic error, output int waits);
    waits = 0;
    stepToDrive();
    psel    = 1'b1;                                  // Setup phase
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = data;
    stepToDrive();
    penable = 1'b1;
    @(negedge clock);
    while (!pready && waits < TimeoutCycles) begin
      waits++;
      @(negedge clock);
    end
    if (!pready) begin
      timeoutCount++;
      $display("Timeout at %0t: pready stayed low for %0d cycles", $time, waits);
    end
    rdata = prdata;
    error = pslverr;
    stepToDrive();
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // --------------------
  // Reference model for one command
  task automatic modelCommand(input logic [3:0] op, input int arr, input int idx,
                              input logic [DataBits-1:0] value,
                              output logic [WordBits-1:0] expected);
    errorCodeT           owner;
    errorCodeT           fault;
    logic [DataBits-1:0] result;
    int                  top;
    owner  = (arr >= mHandedOut) ? notAllocated : (!mAllocated[arr] ? arrayFreed : noError);
    fault  = noError;
    result = '0;
    top    = mSize[arr];
    case (op)
      opClear: begin
        mHandedOut = 0;
        mFreeTop   = 0;
        mAllocated = '0;
      end
      opAlloc: begin
        if (mFreeTop > 0) begin
          mFreeTop--;                                // Last freed comes back first
          result = DataBits'(mFreeStack[mFreeTop]);
        end else if (mHandedOut == ArrayCount) begin
          fault = outOfMemory;
        end else begin
          result = DataBits'(mHandedOut);
          mHandedOut++;
        end
        if (fault == noError) begin
          mAllocated[result] = 1'b1;
          mSize[result]      = 0;
        end
      end
      opFree: begin
        fault = owner;
        if (fault == noError) begin
          mFreeStack[mFreeTop] = arr;
          mFreeTop++;
          mAllocated[arr] = 1'b0;
        end
      end
      opWrite: begin
        fault = owner;
        if (fault == noError) begin
          mMem[arr][idx] = value;
          result         = value;
          if (idx >= top) mSize[arr] = idx + 1;     // Size grows to the highest index
        end
      end
      opSize: begin
        fault  = owner;
        result = DataBits'(top);
      end
      opPush: begin
        fault = owner;
        if (fault == noError && top == ArrayLength) fault = arrayFull;
        if (fault == noError) begin
          mMem[arr][top] = value;
          mSize[arr]     = top + 1;
          result         = value;
        end
      end
      opPop: begin
        fault = owner;
        if (fault == noError && top == 0) fault = arrayEmpty;
        if (fault == noError) begin
          mSize[arr] = top - 1;
          result     = mMem[arr][top-1];
        end
      end
      opRead, opAdd, opSubtract, opAnd, opOr, opXor: begin
        fault = owner;
        if (fault == noError && idx >= top) fault = outOfBounds;
        if (fault == noError) begin
          case (op)
            opRead:     result = mMem[arr][idx];
            opAdd:      result = mMem[arr][idx] + value;
            opSubtract: result = mMem[arr][idx] - value;
            opAnd:      result = mMem[arr][idx] & value;
            opOr:       result = mMem[arr][idx] | value;
            default:    result = mMem[arr][idx] ^ value;
          endcase
          mMem[arr][idx] = result;                   // Read stores the same value back
        end
      end
      default: fault = badOpcode;
    endcase
    expected = (fault != noError) ? {1'b1, 27'd0, fault} : {16'd0, result};
  endtask

  // Issue one command, read the response, compare with the model
  task automatic command(input logic [3:0] op, input int arr, input int idx,
                         input logic [DataBits-1:0] value);
    logic [WordBits-1:0] expected;
    logic [WordBits-1:0] readBack;
    logic                error;
    int                  waits;
    modelCommand(op, arr, idx, value, expected);
    transfer(1'b1, CommandAddr, {4'd0, op, 2'd0, 2'(arr), 2'd0, 2'(idx), value},
             readBack, error, waits);
    compare(waits, 3, "command write wait states");
    compare(error, 1'b0, "pslverr on command write");
    transfer(1'b0, ResultAddr, '0, readBack, error, waits);
    compare(readBack, expected, $sformatf("response to opcode %0d array %0d index %0d",
                                          op, arr, idx));
    lastResponse = expected;
  endtask

  // --------------------
  // Directed tests
  task automatic allocationOrder();
    command(opClear, 0, 0, '0);
    repeat (ArrayCount + 1) command(opAlloc, 0, 0, '0); // Fifth runs out of memory
    command(opFree, 2, 0, '0);
    command(opFree, 0, 0, '0);
    command(opAlloc, 0, 0, '0);
    command(opFree, 2, 0, '0);                       // Double free
  endtask

  task automatic writeReadSize();
    command(opClear, 0, 0, '0);
    command(opAlloc, 0, 0, '0);
    command(opAlloc, 0, 0, '0);
    command(opWrite, 1, 1, randomData());
    command(opWrite, 1, 0, randomData());
    command(opSize, 1, 0, '0);
    command(opRead, 1, 3, '0);                       // Beyond the size
    command(opRead, 1, 2, '0);                       // At the size
    command(opRead, 1, 0, '0);
    command(opRead, 1, 1, '0);
    command(opWrite, 1, 3, randomData());
    command(opWrite, 1, 2, randomData());
    command(opSize, 1, 0, '0);
    command(opRead, 1, 2, '0);
    command(opRead, 1, 3, '0);
    command(opRead, 3, 0, '0);                       // Never handed out
  endtask

  task automatic pushPop();
    repeat (ArrayLength) begin
      command(opPush, 0, 0, randomData());
      command(opSize, 0, 0, '0);
    end
    command(opPush, 0, 0, randomData());             // Full
    repeat (ArrayLength) begin
      command(opPop, 0, 0, '0);
      command(opSize, 0, 0, '0);
    end
    command(opPop, 0, 0, '0);                        // Empty
  endtask

  task automatic readModifyWrite();
    opcodeT rmwOps [5];
    rmwOps = '{opAdd, opSubtract, opAnd, opOr, opXor};
    for (int i = 0; i < 5; i++) begin
      command(rmwOps[i], 1, i % ArrayLength, randomData());
      command(opRead, 1, i % ArrayLength, '0);
    end
    command(opFree, 1, 0, '0);
    command(opSubtract, 1, 0, randomData());         // Fails on a freed array
    command(opAlloc, 0, 0, '0);                      // Same number, size zero
    command(opWrite, 1, 1, randomData());
    command(opRead, 1, 0, '0);                       // Old element untouched
  endtask

  task automatic protocolChecks();
    logic [WordBits-1:0] readBack;
    logic                error;
    int                  waits;
    transfer(1'b0, ResultAddr, '0, readBack, error, waits);
    compare(waits, 0, "result read wait states");
    compare(error, 1'b0, "pslverr on result read");
    compare(readBack, lastResponse, "result read before error transfers");
    command(4'd13, 0, 0, '0);                        // Unused opcode
    transfer(1'b1, 3'd2, '1, readBack, error, waits);
    compare(error, 1'b1, "pslverr on unmapped write");
    compare(waits, 0, "unmapped write wait states");
    transfer(1'b0, CommandAddr, '0, readBack, error, waits);
    compare(error, 1'b1, "pslverr on command register read");
    transfer(1'b0, 3'd6, '0, readBack, error, waits);
    compare(error, 1'b1, "pslverr on unmapped read");
    transfer(1'b0, ResultAddr, '0, readBack, error, waits);
    compare(readBack, lastResponse, "result read after error transfers");
  endtask

  initial begin
    reset   = 1'b1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    repeat (4) @(posedge clock);                     // Reset for four cycles
    #1;
    reset = 1'b0;
    allocationOrder();
    writeReadSize();
    pushPop();
    readModifyWrite();
    protocolChecks();
    $display("Run complete: %0d mismatches, %0d timeouts", errorCount, timeoutCount);
    if (errorCount == 0 && timeoutCount == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
verilog/arrayHeapPkg.sv
verilog/elementStore.sv
verilog/arrayTable.sv
verilog/apbCommandPort.sv
verilog/arrayHeapTop.sv
testbench/arrayHeapAssertions.sv
testbench/arrayHeapTb.sv
